/* list.f */
logic/alpha_pkg.sv
logic/inst_decoder.sv
logic/fetch_latch.sv
logic/decode_stage.sv
logic/decode_front.sv
verif/decode_front_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert --timing
TOP       = decode_front_tb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_bin
	./obj_dir/sim_bin | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* verif/decode_front_tb.sv */
////////////////////
// testbench for the two-wide decode front end
// directed and random pairs go in, a reference decode fills the
// expected queue, and assertions compare every output transfer
////////////////////
module decode_front_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic                   clock;
	logic                   reset;
	alpha_pkg::fetch_pair_t in_pair;
	logic                   in_valid, in_ready;
	alpha_pkg::dec_pair_t   out_pair;
	logic                   out_valid, out_ready, halted;

	integer               seed = 32'h3788;
	int                   errors, test_start, pairs_out, quiet_hits;
	logic                 stall_mode;  // random out_ready gaps
	logic                 halt_sent;   // dut drops everything behind a halt
	alpha_pkg::addr_t     npc_base;
	alpha_pkg::dec_pair_t exp_q[$];
	alpha_pkg::dec_pair_t exp_head, exp_next;
	logic                 exp_empty;

	// legal operate encodings, op and function code side by side
	logic [5:0] op_tab [17] = '{6'h10, 6'h10, 6'h10, 6'h10, 6'h10, 6'h10, 6'h10,
		6'h11, 6'h11, 6'h11, 6'h11, 6'h11, 6'h11, 6'h12, 6'h12, 6'h12, 6'h13};
	logic [6:0] fn_tab [17] = '{7'h20, 7'h29, 7'h2d, 7'h1d, 7'h3d, 7'h4d, 7'h6d,
		7'h00, 7'h08, 7'h20, 7'h28, 7'h40, 7'h48, 7'h34, 7'h39, 7'h3c, 7'h20};
	logic [5:0] mem_tab [5] = '{6'h08, 6'h29, 6'h2b, 6'h2d, 6'h2f};
	logic [5:0] br_tab [8]  = '{6'h30, 6'h34, 6'h1a, 6'h38, 6'h39, 6'h3d, 6'h3f, 6'h3b};

	decode_front DUT (
		.clock     (clock),
		.reset     (reset),
		.in_pair   (in_pair),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_pair  (out_pair),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.halted    (halted)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;  // 8 ns

	always @(posedge clock) begin
		if (stall_mode)
			out_ready <= ($random(seed) & 3) != 0;
		else
			out_ready <= 1'b1;
	end

	////////////////////
	// encoders
	////////////////////
	function automatic alpha_pkg::inst_t enc_operate(logic [5:0] op, logic [6:0] fn,
		logic [4:0] ra, logic [7:0] b, logic lit, logic [4:0] rc);
		if (lit)
			return {op, ra, b, 1'b1, fn, rc};
		else
			return {op, ra, b[4:0], 3'b000, 1'b0, fn, rc};
	endfunction

	function automatic alpha_pkg::inst_t enc_mem(logic [5:0] op, logic [4:0] ra,
		logic [4:0] rb, logic [15:0] disp);
		return {op, ra, rb, disp};
	endfunction

	function automatic alpha_pkg::inst_t enc_branch(logic [5:0] op, logic [4:0] ra,
		logic [20:0] disp);
		return {op, ra, disp};
	endfunction

	function automatic alpha_pkg::inst_t enc_pal(logic [25:0] code);
		return {6'h00, code};
	endfunction

	////////////////////
	// reference decode
	////////////////////
	function automatic alpha_pkg::dec_slot_t expect_slot(alpha_pkg::fetch_slot_t s);
		alpha_pkg::dec_slot_t d;
		logic [5:0]           op;
		logic [6:0]           fn;
		logic [2:0]           grp;
		logic                 bad;
		op  = s.inst[31:26];
		fn  = s.inst[11:5];
		grp = op[5:3];
		bad = 1'b0;
		d          = '0;
		d.opa      = {59'b0, s.inst[25:21]};  // ra tag
		d.opb      = {59'b0, s.inst[20:16]};  // rb tag
		d.dest_idx = alpha_pkg::ZERO_REG;
		d.alu_func = alpha_pkg::ALU_ADDQ;
		if (s.valid) begin
			case (grp)
				3'd0: begin
					if (op == 6'h00 && s.inst[25:0] == 26'h0)
						d.halt = 1'b1;
					else if (op == 6'h00 && s.inst[25:0] == 26'h3c) begin
						d.cpuid    = 1'b1;
						d.dest_idx = s.inst[25:21];
					end else
						bad = 1'b1;
				end
				3'd2: begin
					if (s.inst[12]) begin
						d.opb          = {56'b0, s.inst[20:13]};  // literal
						d.opb_is_value = 1'b1;
					end
					d.dest_idx = s.inst[4:0];
					case ({op, fn})
						{6'h10, 7'h20}: d.alu_func = alpha_pkg::ALU_ADDQ;
						{6'h10, 7'h29}: d.alu_func = alpha_pkg::ALU_SUBQ;
						{6'h10, 7'h2d}: d.alu_func = alpha_pkg::ALU_CMPEQ;
						{6'h10, 7'h1d}: d.alu_func = alpha_pkg::ALU_CMPULT;
						{6'h10, 7'h3d}: d.alu_func = alpha_pkg::ALU_CMPULE;
						{6'h10, 7'h4d}: d.alu_func = alpha_pkg::ALU_CMPLT;
						{6'h10, 7'h6d}: d.alu_func = alpha_pkg::ALU_CMPLE;
						{6'h11, 7'h00}: d.alu_func = alpha_pkg::ALU_AND;
						{6'h11, 7'h08}: d.alu_func = alpha_pkg::ALU_BIC;
						{6'h11, 7'h20}: d.alu_func = alpha_pkg::ALU_BIS;
						{6'h11, 7'h28}: d.alu_func = alpha_pkg::ALU_ORNOT;
						{6'h11, 7'h40}: d.alu_func = alpha_pkg::ALU_XOR;
						{6'h11, 7'h48}: d.alu_func = alpha_pkg::ALU_EQV;
						{6'h12, 7'h34}: d.alu_func = alpha_pkg::ALU_SRL;
						{6'h12, 7'h39}: d.alu_func = alpha_pkg::ALU_SLL;
						{6'h12, 7'h3c}: d.alu_func = alpha_pkg::ALU_SRA;
						{6'h13, 7'h20}: d.alu_func = alpha_pkg::ALU_MULQ;
						default:        bad = 1'b1;
					endcase
				end
				3'd3: begin
					if (op == 6'h1a) begin  // jump target = rb and not 3
						d.opa           = ~64'h3;
						d.opa_is_value  = 1'b1;
						d.alu_func      = alpha_pkg::ALU_AND;
						d.dest_idx      = s.inst[25:21];
						d.uncond_branch = 1'b1;
					end else
						bad = 1'b1;
				end
				3'd1, 3'd4, 3'd5: begin
					d.opa          = {{48{s.inst[15]}}, s.inst[15:0]};
					d.opa_is_value = 1'b1;
					d.dest_idx     = s.inst[25:21];
					case (op)
						6'h08: ;
						6'h29: d.rd_mem = 1'b1;
						6'h2b: begin
							d.rd_mem  = 1'b1;
							d.ldl_mem = 1'b1;
						end
						6'h2d: begin
							d.wr_mem   = 1'b1;
							d.dest_idx = alpha_pkg::ZERO_REG;  // plain store writes nothing
						end
						6'h2f: begin
							d.wr_mem  = 1'b1;
							d.stc_mem = 1'b1;
						end
						default: bad = 1'b1;
					endcase
				end
				default: begin
					d.opa          = s.npc;
					d.opa_is_value = 1'b1;
					d.opb          = {{41{s.inst[20]}}, s.inst[20:0], 2'b00};
					d.opb_is_value = 1'b1;
					if (op == 6'h30 || op == 6'h34) begin
						d.uncond_branch = 1'b1;
						d.dest_idx      = s.inst[25:21];
					end else if (grp == 3'd7)
						d.cond_branch = 1'b1;
					else
						bad = 1'b1;  // fp branch
				end
			endcase
		end
		case (grp)
			3'd1, 3'd4, 3'd5: d.fu_sel = alpha_pkg::FU_MEMORY;
			3'd3, 3'd6, 3'd7: d.fu_sel = alpha_pkg::FU_BRANCH;
			default: d.fu_sel = (d.alu_func == alpha_pkg::ALU_MULQ) ?
				alpha_pkg::FU_MULT : alpha_pkg::FU_ADDER;
		endcase
		d.illegal = bad;
		d.valid   = s.valid & ~bad;
		return d;
	endfunction

	function automatic alpha_pkg::dec_pair_t expect_pair(alpha_pkg::fetch_pair_t p);
		alpha_pkg::dec_pair_t d;
		d.slot1 = expect_slot(p.slot1);
		d.slot2 = expect_slot(p.slot2);
		if (d.slot1.halt)
			d.slot2.valid = 1'b0;  // squashed
		return d;
	endfunction

	////////////////////
	// scoreboard
	////////////////////
	always @(posedge clock) begin
		if (!reset) begin
			if (out_valid && out_ready) begin
				if (exp_q.size() > 0)
					void'(exp_q.pop_front());
				pairs_out++;
			end
			if (in_valid && in_ready && !halt_sent) begin
				exp_next = expect_pair(in_pair);
				exp_q.push_back(exp_next);
				if (exp_next.slot1.halt || exp_next.slot2.halt)
					halt_sent = 1'b1;
			end
		end
	end

	// head refreshed away from the rising edge
	always @(negedge clock) begin
		exp_empty = (exp_q.size() == 0);
		exp_head  = exp_empty ? '0 : exp_q[0];
	end

	task automatic report_err(string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	out_match: assert property (@(posedge clock) disable iff (reset)
		out_valid && out_ready |-> !exp_empty && out_pair == exp_head)
		else report_err("out_pair differs from the reference decode");

	out_hold: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_pair))
		else report_err("held output changed before it was taken");

	reset_state: assert property (@(posedge clock)
		reset |=> !out_valid && !halted && in_ready)
		else report_err("wrong handshake state after reset");

	halt_sticky: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted)
		else report_err("halted dropped before reset");

	halt_quiet: assert property (@(posedge clock) disable iff (reset)
		halted && !out_valid |=> !out_valid)
		else report_err("out_valid rose after the halt drained");

	////////////////////
	// stimulus tasks
	////////////////////
	task automatic send_pair(alpha_pkg::fetch_pair_t p);
		int n;
		in_pair  <= p;
		in_valid <= 1'b1;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!in_ready && n < 200);
		if (!in_ready) begin
			errors++;
			$display("timeout, in_ready stayed low for 200 cycles");
		end
		@(posedge clock);
		in_valid <= 1'b0;
	endtask

	task automatic send_insts(alpha_pkg::inst_t i1, logic v1, alpha_pkg::inst_t i2, logic v2);
		alpha_pkg::fetch_pair_t p;
		p.slot1 = '{valid: v1, inst: i1, npc: npc_base + 64'd4};
		p.slot2 = '{valid: v2, inst: i2, npc: npc_base + 64'd8};
		npc_base = npc_base + 64'd8;
		send_pair(p);
	endtask

	task automatic drain(int limit);
		int n;
		n = 0;
		@(negedge clock);
		while (exp_q.size() != 0 && n < limit) begin
			@(negedge clock);
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("timeout, %0d expected pairs never left the DUT", exp_q.size());
		end
		@(posedge clock);
	endtask

	task automatic end_test(string name);
		$display("%s: %s, %0d errors", name, (errors == test_start) ? "ok" : "failed",
			errors - test_start);
		test_start = errors;
	endtask

	function automatic alpha_pkg::inst_t rand_inst();
		logic [31:0] r;
		int          k;
		int          idx;
		r = $random(seed);
		k = $random(seed) & 7;
		case (k)
			0, 1: begin
				idx = r[4:0] % 17;
				return enc_operate(op_tab[idx], fn_tab[idx], r[25:21], r[20:13], r[12], r[4:0]);
			end
			2: begin
				idx = r[31:29] % 5;
				return enc_mem(mem_tab[idx], r[25:21], r[20:16], r[15:0]);
			end
			3: return enc_branch(br_tab[r[31:29]], r[25:21], r[20:0]);
			4: return enc_pal(26'h3c);  // whami
			default: begin
				if (r[31:29] == 3'd0)
					r[31:26] = 6'h16;  // keep pal halt out of random traffic
				return r;
			end
		endcase
	endfunction

	////////////////////
	// tests
	////////////////////
	initial begin
		reset      = 1'b1;
		in_valid   = 1'b0;
		in_pair    = '0;
		out_ready  = 1'b1;
		stall_mode = 1'b0;
		halt_sent  = 1'b0;
		errors     = 0;
		test_start = 0;
		pairs_out  = 0;
		quiet_hits = 0;
		npc_base   = 64'h0000_0000_0001_0000;
		exp_empty  = 1'b1;
		exp_head   = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		for (int i = 0; i < 17; i++)  // register b in slot 1, literal in slot 2
			send_insts(enc_operate(op_tab[i], fn_tab[i], 5'(i), 8'(i + 3), 1'b0, 5'(30 - i)), 1'b1,
				enc_operate(op_tab[i], fn_tab[i], 5'(i + 1), 8'(8'hf0 + i), 1'b1, 5'(i)), 1'b1);
		drain(100);
		end_test("operate");

		for (int i = 0; i < 5; i++)
			send_insts(enc_mem(mem_tab[i], 5'(i + 2), 5'(i + 9), 16'(16'h0123 + i)), 1'b1,
				enc_mem(mem_tab[i], 5'(i + 20), 5'(i), 16'(16'hff80 - i)), 1'b1);
		drain(100);
		end_test("memory");

		for (int i = 0; i < 8; i++)
			send_insts(enc_branch(br_tab[i], 5'(i + 26), 21'(21'h00010 + i)), 1'b1,
				enc_branch(br_tab[i], 5'(i), 21'(21'h1ffff0 - i)), 1'b1);
		drain(100);
		end_test("branch");

		send_insts(enc_operate(6'h16, 7'h20, 5'd1, 8'd2, 1'b0, 5'd3), 1'b1,
			enc_operate(6'h10, 7'h7f, 5'd4, 8'd5, 1'b0, 5'd6), 1'b1);
		send_insts(enc_pal(26'h99), 1'b1, enc_branch(6'h31, 5'd7, 21'h40), 1'b1);
		send_insts(enc_mem(6'h29, 5'd8, 5'd9, 16'h10), 1'b0, enc_pal(26'h3c), 1'b1);
		send_insts(enc_mem(6'h1c, 5'd1, 5'd2, 16'h3), 1'b1, enc_mem(6'h09, 5'd3, 5'd4, 16'h8), 1'b1);
		send_insts(enc_pal(26'h0), 1'b0, enc_operate(6'h13, 7'h20, 5'd1, 8'd2, 1'b0, 5'd3), 1'b0);
		drain(100);
		end_test("illegal and invalid");

		stall_mode <= 1'b1;
		for (int i = 0; i < 200; i++) begin
			if (($random(seed) & 3) == 0)
				repeat (1 + ($random(seed) & 3)) @(posedge clock);  // in_valid gap
			send_insts(rand_inst(), ($random(seed) & 7) != 0, rand_inst(), ($random(seed) & 7) != 0);
		end
		drain(2000);
		stall_mode <= 1'b0;
		end_test("random");

		send_insts(enc_pal(26'h0), 1'b1, enc_operate(6'h10, 7'h20, 5'd1, 8'd2, 1'b0, 5'd3), 1'b1);
		for (int i = 0; i < 3; i++)
			send_insts(enc_mem(6'h29, 5'(i), 5'd2, 16'h8), 1'b1, enc_branch(6'h30, 5'd26, 21'h4), 1'b1);
		drain(100);
		for (int n = 0; n < 20; n++) begin
			@(negedge clock);
			if (out_valid)
				quiet_hits++;
		end
		if (!halted)
			report_err("halted never went high after a halt pair");
		if (quiet_hits != 0)
			report_err("output still produced pairs after the halt");
		end_test("halt");

		$display("%0d pairs out, %0d errors", pairs_out, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* logic/decode_front.sv */
////////////////////
// two-wide decode front end, fetch latch then decode stage
// in_* from fetch, out_* to dispatch, two pairs in flight at most
////////////////////
module decode_front (
	input  logic                   clock,
	input  logic                   reset,
	input  alpha_pkg::fetch_pair_t in_pair,
	input  logic                   in_valid,
	output logic                   in_ready,
	output alpha_pkg::dec_pair_t   out_pair,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   halted
);

	// latch to decode link
	alpha_pkg::fetch_pair_t fl_pair;
	logic                   fl_valid;
	logic                   fl_ready;

	fetch_latch latch (
		.clock    (clock),
		.reset    (reset),
		.in_pair  (in_pair),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.fl_pair  (fl_pair),
		.fl_valid (fl_valid),
		.fl_ready (fl_ready)
	);

	decode_stage decode (
		.clock     (clock),
		.reset     (reset),
		.fl_pair   (fl_pair),
		.fl_valid  (fl_valid),
		.fl_ready  (fl_ready),
		.out_pair  (out_pair),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.halted    (halted)     // sticky after a halt
	);

endmodule

/* logic/decode_stage.sv */
////////////////////
// id stage, decodes both slots of the latched pair, builds operand
// values or tags, and registers the result for dispatch
// a halt stops the stage until reset
////////////////////
module decode_stage (
	input  logic                   clock,
	input  logic                   reset,
	input  alpha_pkg::fetch_pair_t fl_pair,
	input  logic                   fl_valid,
	output logic                   fl_ready,
	output alpha_pkg::dec_pair_t   out_pair,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   halted
);

	typedef enum logic {RUN, HALTED} run_state_t;

	run_state_t           run_state;
	alpha_pkg::ctrl_t     ctrl1, ctrl2;
	alpha_pkg::dec_pair_t dec_pair;
	logic                 take;  // pair accepted and kept

	// operand, destination and unit muxes for one slot
	function automatic alpha_pkg::dec_slot_t build_slot(
		input alpha_pkg::fetch_slot_t s,
		input alpha_pkg::ctrl_t       c
	);
		alpha_pkg::dec_slot_t d;
		alpha_pkg::reg_idx_t  ra, rb, rc;
		ra = s.inst[25:21];
		rb = s.inst[20:16];
		rc = s.inst[4:0];
		case (c.opa_sel)
			alpha_pkg::OPA_REGA:     d.opa = {59'b0, ra};  // tag
			alpha_pkg::OPA_MEM_DISP: d.opa = {{48{s.inst[15]}}, s.inst[15:0]};
			alpha_pkg::OPA_NPC:      d.opa = s.npc;
			default:                 d.opa = ~64'h3;  // jsr align mask
		endcase
		d.opa_is_value = (c.opa_sel != alpha_pkg::OPA_REGA);
		case (c.opb_sel)
			alpha_pkg::OPB_ALU_IMM: d.opb = {56'b0, s.inst[20:13]};  // zero-ext literal
			alpha_pkg::OPB_BR_DISP: d.opb = {{41{s.inst[20]}}, s.inst[20:0], 2'b00};
			default:                d.opb = {59'b0, rb};
		endcase
		d.opb_is_value = (c.opb_sel == alpha_pkg::OPB_ALU_IMM) ||
			(c.opb_sel == alpha_pkg::OPB_BR_DISP);
		case (c.dest_sel)
			alpha_pkg::DEST_REGA: d.dest_idx = ra;
			alpha_pkg::DEST_REGC: d.dest_idx = rc;
			default:              d.dest_idx = alpha_pkg::ZERO_REG;
		endcase
		case ({s.inst[31:29], 3'b000})  // unit class by opcode group
			6'h08, 6'h20, 6'h28: d.fu_sel = alpha_pkg::FU_MEMORY;
			6'h18, 6'h30, 6'h38: d.fu_sel = alpha_pkg::FU_BRANCH;
			default: d.fu_sel = (c.alu_func == alpha_pkg::ALU_MULQ) ?
				alpha_pkg::FU_MULT : alpha_pkg::FU_ADDER;
		endcase
		d.valid         = c.valid;
		d.alu_func      = c.alu_func;
		d.rd_mem        = c.rd_mem;
		d.wr_mem        = c.wr_mem;
		d.ldl_mem       = c.ldl_mem;
		d.stc_mem       = c.stc_mem;
		d.cond_branch   = c.cond_branch;
		d.uncond_branch = c.uncond_branch;
		d.halt          = c.halt;
		d.cpuid         = c.cpuid;
		d.illegal       = c.illegal;
		return d;
	endfunction

	inst_decoder dec1 (
		.inst     (fl_pair.slot1.inst),
		.valid_in (fl_pair.slot1.valid),
		.ctrl     (ctrl1)
	);

	inst_decoder dec2 (
		.inst     (fl_pair.slot2.inst),
		.valid_in (fl_pair.slot2.valid),
		.ctrl     (ctrl2)
	);

	always_comb begin
		dec_pair.slot1 = build_slot(fl_pair.slot1, ctrl1);
		dec_pair.slot2 = build_slot(fl_pair.slot2, ctrl2);
		if (ctrl1.halt)
			dec_pair.slot2.valid = 1'b0;  // squash behind a slot-1 halt
	end

	////////////////////
	// output register and halt tracker
	////////////////////
	assign halted   = (run_state == HALTED);
	assign fl_ready = halted | ~out_valid | out_ready;  // halted drains the latch
	assign take     = fl_valid & fl_ready & ~halted;

	always_ff @(posedge clock) begin
		if (reset) begin
			run_state <= RUN;
			out_valid <= 1'b0;
		end else begin
			if (take)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
			if (take && (ctrl1.halt || ctrl2.halt))
				run_state <= HALTED;  // sticky until reset
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			out_pair <= dec_pair;
	end

	// nothing new leaves once the halting pair is gone
	halt_drained: assert property (@(posedge clock) disable iff (reset)
		halted && !out_valid |=> !out_valid)
		else $error("decode stage issued a pair after halting");

	halt_squash: assert property (@(posedge clock) disable iff (reset)
		take && ctrl1.halt |=> out_valid && !out_pair.slot2.valid)
		else $error("slot 2 behind a halt left the stage valid");

endmodule

/* logic/fetch_latch.sv */
////////////////////
// if/id pipeline register for one instruction pair
// valid/ready on both sides, holds its pair while decode stalls
////////////////////
module fetch_latch (
	input  logic                   clock,
	input  logic                   reset,
	input  alpha_pkg::fetch_pair_t in_pair,
	input  logic                   in_valid,
	output logic                   in_ready,
	output alpha_pkg::fetch_pair_t fl_pair,
	output logic                   fl_valid,
	input  logic                   fl_ready
);

	logic in_xfer;

	assign in_ready = ~fl_valid | fl_ready;  // empty, or drained this edge
	assign in_xfer  = in_valid & in_ready;

	always_ff @(posedge clock) begin
		if (reset)
			fl_valid <= 1'b0;
		else if (in_ready)
			fl_valid <= in_valid;  // refill or go empty
	end

	// payload only moves on a transfer
	always_ff @(posedge clock) begin
		if (in_xfer)
			fl_pair <= in_pair;
	end

	////////////////////
	// checks
	////////////////////
	hold_stable: assert property (@(posedge clock) disable iff (reset)
		fl_valid && !fl_ready |=> fl_valid && $stable(fl_pair))
		else $error("fetch latch changed a pair that decode had not taken");

endmodule

/* logic/inst_decoder.sv */
////////////////////
// combinational decode of one alpha integer instruction into
// mux selects and control flags, one copy per dispatch slot
////////////////////
module inst_decoder (
	input  alpha_pkg::inst_t inst,
	input  logic             valid_in,  // low gives no-op controls
	output alpha_pkg::ctrl_t ctrl
);

	alpha_pkg::opcode_t    op;
	alpha_pkg::func_code_t fn;

	assign op = inst[31:26];
	assign fn = inst[11:5];

	always_comb begin
		// no-op defaults
		ctrl          = '0;
		ctrl.opa_sel  = alpha_pkg::OPA_REGA;
		ctrl.opb_sel  = alpha_pkg::OPB_REGB;
		ctrl.alu_func = alpha_pkg::ALU_ADDQ;
		ctrl.dest_sel = alpha_pkg::DEST_NONE;
		if (valid_in) begin
			case ({op[5:3], 3'b000})  // split on opcode group
				6'h00: begin
					// pal group, only halt and whami exist here
					if (op == alpha_pkg::PAL_INST && inst[25:0] == alpha_pkg::PAL_HALT)
						ctrl.halt = 1'b1;
					else if (op == alpha_pkg::PAL_INST && inst[25:0] == alpha_pkg::PAL_WHAMI) begin
						ctrl.cpuid    = 1'b1;
						ctrl.dest_sel = alpha_pkg::DEST_REGA;  // cpu id lands in ra
					end else
						ctrl.illegal = 1'b1;
				end
				6'h10: begin
					ctrl.opa_sel  = alpha_pkg::OPA_REGA;
					ctrl.opb_sel  = inst[12] ? alpha_pkg::OPB_ALU_IMM : alpha_pkg::OPB_REGB;
					ctrl.dest_sel = alpha_pkg::DEST_REGC;
					case (op)
						alpha_pkg::INTA_GRP: case (fn)
							alpha_pkg::FN_ADDQ:   ctrl.alu_func = alpha_pkg::ALU_ADDQ;
							alpha_pkg::FN_SUBQ:   ctrl.alu_func = alpha_pkg::ALU_SUBQ;
							alpha_pkg::FN_CMPEQ:  ctrl.alu_func = alpha_pkg::ALU_CMPEQ;
							alpha_pkg::FN_CMPULT: ctrl.alu_func = alpha_pkg::ALU_CMPULT;
							alpha_pkg::FN_CMPULE: ctrl.alu_func = alpha_pkg::ALU_CMPULE;
							alpha_pkg::FN_CMPLT:  ctrl.alu_func = alpha_pkg::ALU_CMPLT;
							alpha_pkg::FN_CMPLE:  ctrl.alu_func = alpha_pkg::ALU_CMPLE;
							default:              ctrl.illegal  = 1'b1;
						endcase
						alpha_pkg::INTL_GRP: case (fn)
							alpha_pkg::FN_AND:   ctrl.alu_func = alpha_pkg::ALU_AND;
							alpha_pkg::FN_BIC:   ctrl.alu_func = alpha_pkg::ALU_BIC;
							alpha_pkg::FN_BIS:   ctrl.alu_func = alpha_pkg::ALU_BIS;
							alpha_pkg::FN_ORNOT: ctrl.alu_func = alpha_pkg::ALU_ORNOT;
							alpha_pkg::FN_XOR:   ctrl.alu_func = alpha_pkg::ALU_XOR;
							alpha_pkg::FN_EQV:   ctrl.alu_func = alpha_pkg::ALU_EQV;
							default:             ctrl.illegal  = 1'b1;
						endcase
						alpha_pkg::INTS_GRP: case (fn)
							alpha_pkg::FN_SRL: ctrl.alu_func = alpha_pkg::ALU_SRL;
							alpha_pkg::FN_SLL: ctrl.alu_func = alpha_pkg::ALU_SLL;
							alpha_pkg::FN_SRA: ctrl.alu_func = alpha_pkg::ALU_SRA;
							default:           ctrl.illegal  = 1'b1;
						endcase
						alpha_pkg::INTM_GRP: begin
							if (fn == alpha_pkg::FN_MULQ)
								ctrl.alu_func = alpha_pkg::ALU_MULQ;
							else
								ctrl.illegal = 1'b1;
						end
						default: ctrl.illegal = 1'b1;  // itfp and fp operate groups
					endcase
				end
				6'h18: begin
					if (op == alpha_pkg::JSR_GRP) begin
						// jmp, jsr, ret share one form, target is rb with low bits cleared
						ctrl.opa_sel       = alpha_pkg::OPA_NOT3;
						ctrl.opb_sel       = alpha_pkg::OPB_REGB;
						ctrl.alu_func      = alpha_pkg::ALU_AND;
						ctrl.dest_sel      = alpha_pkg::DEST_REGA;  // return address
						ctrl.uncond_branch = 1'b1;
					end else
						ctrl.illegal = 1'b1;  // misc, ftpi
				end
				6'h08, 6'h20, 6'h28: begin
					// ea = sign-extended disp + rb
					ctrl.opa_sel  = alpha_pkg::OPA_MEM_DISP;
					ctrl.opb_sel  = alpha_pkg::OPB_REGB;
					ctrl.alu_func = alpha_pkg::ALU_ADDQ;
					ctrl.dest_sel = alpha_pkg::DEST_REGA;
					case (op)
						alpha_pkg::LDA_INST: ;  // address only
						alpha_pkg::LDQ_INST:
							ctrl.rd_mem = 1'b1;
						alpha_pkg::LDQ_L_INST: begin
							ctrl.rd_mem  = 1'b1;
							ctrl.ldl_mem = 1'b1;
						end
						alpha_pkg::STQ_INST: begin
							ctrl.wr_mem   = 1'b1;
							ctrl.dest_sel = alpha_pkg::DEST_NONE;
						end
						alpha_pkg::STQ_C_INST: begin
							ctrl.wr_mem = 1'b1;
							ctrl.stc_mem = 1'b1;  // success flag back to ra
						end
						default: ctrl.illegal = 1'b1;
					endcase
				end
				default: begin
					// 30 and 38 groups, target = npc + disp
					ctrl.opa_sel  = alpha_pkg::OPA_NPC;
					ctrl.opb_sel  = alpha_pkg::OPB_BR_DISP;
					ctrl.alu_func = alpha_pkg::ALU_ADDQ;
					if (op == alpha_pkg::BR_INST || op == alpha_pkg::BSR_INST) begin
						ctrl.dest_sel      = alpha_pkg::DEST_REGA;  // link register
						ctrl.uncond_branch = 1'b1;
					end else if (op[3])
						ctrl.cond_branch = 1'b1;  // integer conditionals
					else
						ctrl.illegal = 1'b1;  // fp conditionals
				end
			endcase
		end
		ctrl.valid = valid_in & ~ctrl.illegal;
	end

endmodule

/* logic/alpha_pkg.sv */
////////////////////
// shared types, encodings and pipeline payloads for the two-wide
// alpha integer decode front end
// modules reach everything here through alpha_pkg:: scoped names
////////////////////
package alpha_pkg;

	// widths that carry a meaning
	typedef logic [31:0] inst_t;
	typedef logic [63:0] addr_t;       // npc and operand values
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;     // inst[31:26]
	typedef logic [6:0]  func_code_t;  // inst[11:5], operate format
	typedef logic [25:0] pal_code_t;   // inst[25:0], pal format
	typedef logic [4:0]  alu_func_t;
	typedef logic [1:0]  opa_sel_t;
	typedef logic [1:0]  opb_sel_t;
	typedef logic [1:0]  dest_sel_t;
	typedef logic [1:0]  fu_sel_t;

	////////////////////
	// major opcodes
	////////////////////
	localparam opcode_t PAL_INST   = 6'h00;
	localparam opcode_t LDA_INST   = 6'h08;
	localparam opcode_t INTA_GRP   = 6'h10;
	localparam opcode_t INTL_GRP   = 6'h11;
	localparam opcode_t INTS_GRP   = 6'h12;
	localparam opcode_t INTM_GRP   = 6'h13;  // 14-17 are fp groups
	localparam opcode_t JSR_GRP    = 6'h1a;
	localparam opcode_t LDQ_INST   = 6'h29;
	localparam opcode_t LDQ_L_INST = 6'h2b;
	localparam opcode_t STQ_INST   = 6'h2d;
	localparam opcode_t STQ_C_INST = 6'h2f;
	localparam opcode_t BR_INST    = 6'h30;  // 31-37 other than bsr are fp branches
	localparam opcode_t BSR_INST   = 6'h34;

	// operate function codes, one case table per group
	localparam func_code_t FN_ADDQ   = 7'h20;
	localparam func_code_t FN_SUBQ   = 7'h29;
	localparam func_code_t FN_CMPEQ  = 7'h2d;
	localparam func_code_t FN_CMPULT = 7'h1d;
	localparam func_code_t FN_CMPULE = 7'h3d;
	localparam func_code_t FN_CMPLT  = 7'h4d;
	localparam func_code_t FN_CMPLE  = 7'h6d;
	localparam func_code_t FN_AND    = 7'h00;
	localparam func_code_t FN_BIC    = 7'h08;
	localparam func_code_t FN_BIS    = 7'h20;
	localparam func_code_t FN_ORNOT  = 7'h28;
	localparam func_code_t FN_XOR    = 7'h40;
	localparam func_code_t FN_EQV    = 7'h48;
	localparam func_code_t FN_SRL    = 7'h34;
	localparam func_code_t FN_SLL    = 7'h39;
	localparam func_code_t FN_SRA    = 7'h3c;
	localparam func_code_t FN_MULQ   = 7'h20;

	localparam pal_code_t PAL_HALT  = 26'h0000;
	localparam pal_code_t PAL_WHAMI = 26'h003c;
	localparam reg_idx_t  ZERO_REG  = 5'd31;

	////////////////////
	// alu functions and selects
	////////////////////
	localparam alu_func_t ALU_ADDQ = 5'h00, ALU_SUBQ = 5'h01, ALU_AND = 5'h02;
	localparam alu_func_t ALU_BIC = 5'h03, ALU_BIS = 5'h04, ALU_ORNOT = 5'h05;
	localparam alu_func_t ALU_XOR = 5'h06, ALU_EQV = 5'h07, ALU_SRL = 5'h08;
	localparam alu_func_t ALU_SLL = 5'h09, ALU_SRA = 5'h0a, ALU_MULQ = 5'h0b;
	localparam alu_func_t ALU_CMPEQ = 5'h0c, ALU_CMPLT = 5'h0d, ALU_CMPLE = 5'h0e;
	localparam alu_func_t ALU_CMPULT = 5'h0f, ALU_CMPULE = 5'h10;

	localparam opa_sel_t OPA_REGA = 2'd0, OPA_MEM_DISP = 2'd1;
	localparam opa_sel_t OPA_NPC = 2'd2, OPA_NOT3 = 2'd3;
	localparam opb_sel_t OPB_REGB = 2'd0, OPB_ALU_IMM = 2'd1, OPB_BR_DISP = 2'd2;
	localparam dest_sel_t DEST_NONE = 2'd0, DEST_REGA = 2'd1, DEST_REGC = 2'd2;
	localparam fu_sel_t FU_ADDER = 2'd0, FU_MULT = 2'd1;
	localparam fu_sel_t FU_MEMORY = 2'd2, FU_BRANCH = 2'd3;

	////////////////////
	// payloads
	////////////////////
	typedef struct packed {
		opa_sel_t  opa_sel;
		opb_sel_t  opb_sel;
		dest_sel_t dest_sel;
		alu_func_t alu_func;
		logic      rd_mem, wr_mem, ldl_mem, stc_mem;
		logic      cond_branch, uncond_branch;
		logic      halt, cpuid, illegal;
		logic      valid;  // valid_in and not illegal
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		inst_t inst;
		addr_t npc;
	} fetch_slot_t;

	typedef struct packed {
		fetch_slot_t slot1;
		fetch_slot_t slot2;  // younger slot
	} fetch_pair_t;

	typedef struct packed {
		logic      valid;
		addr_t     opa;
		logic      opa_is_value;  // low means opa holds a register tag
		addr_t     opb;
		logic      opb_is_value;
		reg_idx_t  dest_idx;      // ZERO_REG when nothing is written
		alu_func_t alu_func;
		fu_sel_t   fu_sel;
		logic      rd_mem, wr_mem, ldl_mem, stc_mem;
		logic      cond_branch, uncond_branch;
		logic      halt, cpuid, illegal;
	} dec_slot_t;

	typedef struct packed {
		dec_slot_t slot1;
		dec_slot_t slot2;
	} dec_pair_t;

endpackage
